// File: mp64_bus_pkg.sv
`default_nettype none

package mp64_bus_pkg;

    // ============================================================
    // Core count and grant index
    // ============================================================

    // Number of cores that share each memory port
    localparam int NUM_CORES    = 4;

    // Grant index width, enough to name any core
    localparam int CORE_ID_BITS = 2;

    // ============================================================
    // Memory-path widths
    // ============================================================

    // On-chip memory takes a word address
    localparam int TILE_ADDR_W  = 20;

    // External memory takes a full byte address
    localparam int EXT_ADDR_W   = 64;

    // Width of one tile transfer, on both paths
    localparam int TILE_DATA_W  = 64;

    // ============================================================
    // Tile request payloads
    // ============================================================

    // On-chip request, 85 bits
    typedef struct packed {
        logic [TILE_ADDR_W-1:0] addr;
        logic                   wen;
        logic [TILE_DATA_W-1:0] wdata;
    } tile_int_req_t;

    // External request, 129 bits
    // Same fields as on-chip, wide address only
    typedef struct packed {
        logic [EXT_ADDR_W-1:0]  addr;
        logic                   wen;
        logic [TILE_DATA_W-1:0] wdata;
    } tile_ext_req_t;

endpackage

`default_nettype wire

// File: mp64_fabric.f
+incdir+.
mp64_bus_pkg.sv
mp64_mmio_pkg.sv
mp64_rr_arbiter.sv
mp64_mmio_decode.sv
mp64_fabric.sv
tb_clock_gen.sv
tb_mp64_fabric.sv

// File: mp64_fabric.sv
`timescale 1ns/1ns
`default_nettype none

module mp64_fabric
    import mp64_bus_pkg::*;
    import mp64_mmio_pkg::*;
(
    input  wire logic                             sys_clk,
    input  wire logic                             sys_rst_n,

    // On-chip tile requesters, flat per core
    input  wire logic [NUM_CORES-1:0]             tile_req,
    input  wire logic [NUM_CORES*TILE_ADDR_W-1:0] tile_addr,
    input  wire logic [NUM_CORES-1:0]             tile_wen,
    input  wire logic [NUM_CORES*TILE_DATA_W-1:0] tile_wdata,
    output logic      [NUM_CORES-1:0]             tile_ack,
    output logic      [TILE_DATA_W-1:0]           tile_rdata,

    // On-chip memory port
    output logic                                  mem_req,
    output logic      [TILE_ADDR_W-1:0]           mem_addr,
    output logic                                  mem_wen,
    output logic      [TILE_DATA_W-1:0]           mem_wdata,
    input  wire logic [TILE_DATA_W-1:0]           mem_rdata,
    input  wire logic                             mem_ack,

    // External tile requesters, flat per core
    input  wire logic [NUM_CORES-1:0]             ext_req,
    input  wire logic [NUM_CORES*EXT_ADDR_W-1:0]  ext_addr,
    input  wire logic [NUM_CORES-1:0]             ext_wen,
    input  wire logic [NUM_CORES*TILE_DATA_W-1:0] ext_wdata,
    output logic      [NUM_CORES-1:0]             ext_ack,
    output logic      [TILE_DATA_W-1:0]           ext_rdata,

    // External memory tile port
    output logic                                  xmem_req,
    output logic      [EXT_ADDR_W-1:0]            xmem_addr,
    output logic                                  xmem_wen,
    output logic      [TILE_DATA_W-1:0]           xmem_wdata,
    input  wire logic [TILE_DATA_W-1:0]           xmem_rdata,
    input  wire logic                             xmem_ack,

    // MMIO
    input  wire logic                             mmio_req,
    input  wire logic [MMIO_ADDR_W-1:0]           mmio_addr,
    input  wire logic                             mmio_wen,
    input  wire logic [MMIO_DATA_W-1:0]           mmio_wdata,
    output logic      [MMIO_DATA_W-1:0]           mmio_rdata,
    output logic                                  mmio_ack,

    // Peripheral side
    output logic                                  uart_sel,
    output logic                                  timer_sel,
    output logic                                  disk_sel,
    output logic                                  nic_sel,
    output logic                                  mbox_sel,
    output logic                                  periph_wen,
    output logic      [MMIO_DATA_W-1:0]           periph_wdata,
    input  wire logic [PERIPH_DATA_W-1:0]         uart_rdata,
    input  wire logic [PERIPH_DATA_W-1:0]         timer_rdata,
    input  wire logic [PERIPH_DATA_W-1:0]         disk_rdata,
    input  wire logic [PERIPH_DATA_W-1:0]         nic_rdata,
    input  wire logic [PERIPH_DATA_W-1:0]         mbox_rdata
);

    // ============================================================
    // Payload packing
    // ============================================================
    tile_int_req_t tile_pl [NUM_CORES];
    tile_ext_req_t ext_pl  [NUM_CORES];
    tile_int_req_t mem_pl;
    tile_ext_req_t xmem_pl;

    // One payload per core from its slice of the flat buses
    for (genvar i = 0; i < NUM_CORES; i++) begin : g_pack
        assign tile_pl[i] = '{addr:  tile_addr[i*TILE_ADDR_W +: TILE_ADDR_W],
                              wen:   tile_wen[i],
                              wdata: tile_wdata[i*TILE_DATA_W +: TILE_DATA_W]};
        assign ext_pl[i]  = '{addr:  ext_addr[i*EXT_ADDR_W +: EXT_ADDR_W],
                              wen:   ext_wen[i],
                              wdata: ext_wdata[i*TILE_DATA_W +: TILE_DATA_W]};
    end

    // ============================================================
    // On-chip memory arbiter
    // ============================================================
    mp64_rr_arbiter #(
        .payload_t   (tile_int_req_t)
    ) u_tile_arb (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .req_valid   (tile_req),
        .req_payload (tile_pl),
        .req_ack     (tile_ack),
        .req_rdata   (tile_rdata),
        .out_req     (mem_req),
        .out_payload (mem_pl),
        .out_rdata   (mem_rdata),
        .out_ack     (mem_ack)
    );

    assign mem_addr  = mem_pl.addr;
    assign mem_wen   = mem_pl.wen;
    assign mem_wdata = mem_pl.wdata;

    // ============================================================
    // External memory arbiter
    // ============================================================

    // Independent of the on-chip arbiter, own grant history
    mp64_rr_arbiter #(
        .payload_t   (tile_ext_req_t)
    ) u_ext_arb (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .req_valid   (ext_req),
        .req_payload (ext_pl),
        .req_ack     (ext_ack),
        .req_rdata   (ext_rdata),
        .out_req     (xmem_req),
        .out_payload (xmem_pl),
        .out_rdata   (xmem_rdata),
        .out_ack     (xmem_ack)
    );

    assign xmem_addr  = xmem_pl.addr;
    assign xmem_wen   = xmem_pl.wen;
    assign xmem_wdata = xmem_pl.wdata;

    // ============================================================
    // MMIO decode
    // ============================================================
    mp64_mmio_decode u_mmio (
        .mmio_req    (mmio_req),
        .mmio_addr   (mmio_addr),
        .mmio_rdata  (mmio_rdata),
        .mmio_ack    (mmio_ack),
        .uart_sel    (uart_sel),
        .timer_sel   (timer_sel),
        .disk_sel    (disk_sel),
        .nic_sel     (nic_sel),
        .mbox_sel    (mbox_sel),
        .uart_rdata  (uart_rdata),
        .timer_rdata (timer_rdata),
        .disk_rdata  (disk_rdata),
        .nic_rdata   (nic_rdata),
        .mbox_rdata  (mbox_rdata)
    );

    // Write strobe and data go to every peripheral, the select picks the target
    assign periph_wen   = mmio_wen;
    assign periph_wdata = mmio_wdata;

endmodule

`default_nettype wire

// File: mp64_mmio_decode.sv
`timescale 1ns/1ns
`default_nettype none

module mp64_mmio_decode
    import mp64_mmio_pkg::*;
    import mp64_bus_pkg::*;
(
    // MMIO request
    input  wire logic                     mmio_req,
    input  wire logic [MMIO_ADDR_W-1:0]   mmio_addr,
    output logic      [MMIO_DATA_W-1:0]   mmio_rdata,
    output logic                          mmio_ack,

    // Peripheral selects
    output logic                          uart_sel,
    output logic                          timer_sel,
    output logic                          disk_sel,
    output logic                          nic_sel,
    output logic                          mbox_sel,

    // Peripheral read bytes
    input  wire logic [PERIPH_DATA_W-1:0] uart_rdata,
    input  wire logic [PERIPH_DATA_W-1:0] timer_rdata,
    input  wire logic [PERIPH_DATA_W-1:0] disk_rdata,
    input  wire logic [PERIPH_DATA_W-1:0] nic_rdata,
    input  wire logic [PERIPH_DATA_W-1:0] mbox_rdata
);

    // ============================================================
    // Region decode
    // ============================================================
    logic [REGION_W-1:0]      region;
    logic [SYSINFO_OFS_W-1:0] sysinfo_ofs;
    logic                     sysinfo_sel;
    logic [MMIO_DATA_W-1:0]   sysinfo_rdata;

    assign region      = mmio_addr[MMIO_ADDR_W-1 -: REGION_W];
    assign sysinfo_ofs = mmio_addr[SYSINFO_OFS_W-1:0];

    // Selects only while a request is live
    assign uart_sel    = mmio_req && (region == REGION_UART);
    assign timer_sel   = mmio_req && (region == REGION_TIMER);
    assign disk_sel    = mmio_req && (region == REGION_DISK);
    assign sysinfo_sel = mmio_req && (region == REGION_SYSINFO);
    assign nic_sel     = mmio_req && (region == REGION_NIC);
    // Mailbox and spinlocks share one block
    assign mbox_sel    = mmio_req && ((region == REGION_MBOX) ||
                                      (region == REGION_SPINLOCK));

    // ============================================================
    // System-information registers
    // ============================================================
    always_comb begin
        case (sysinfo_ofs)
            SYSINFO_OFS_ID:    sysinfo_rdata = SYSINFO_ID;
            SYSINFO_OFS_RAM:   sysinfo_rdata = RAM_SIZE_BYTES;
            SYSINFO_OFS_CORES: sysinfo_rdata = MMIO_DATA_W'(NUM_CORES);
            // Reserved offsets read as zero
            default:           sysinfo_rdata = '0;
        endcase
    end

    // ============================================================
    // Read-data mux
    // ============================================================

    // Peripheral bytes are zero-extended
    always_comb begin
        mmio_rdata = '0;
        if (uart_sel) begin
            mmio_rdata = MMIO_DATA_W'(uart_rdata);
        end else if (timer_sel) begin
            mmio_rdata = MMIO_DATA_W'(timer_rdata);
        end else if (disk_sel) begin
            mmio_rdata = MMIO_DATA_W'(disk_rdata);
        end else if (nic_sel) begin
            mmio_rdata = MMIO_DATA_W'(nic_rdata);
        end else if (mbox_sel) begin
            mmio_rdata = MMIO_DATA_W'(mbox_rdata);
        end else if (sysinfo_sel) begin
            mmio_rdata = sysinfo_rdata;
        end
        // Unmapped regions fall through to zero
    end

    // Every region answers in the request cycle
    assign mmio_ack = mmio_req;

    // At most one target per access, sysinfo included
    // A live request must carry a known address
    always_comb begin
        a_sel_onehot: assert final ($onehot0({uart_sel, timer_sel, disk_sel,
                                              sysinfo_sel, nic_sel, mbox_sel}) &&
                                    (!mmio_req || !$isunknown(mmio_addr)))
            else $error("mmio decode: overlapping selects or unknown address");
    end

endmodule

`default_nettype wire

// File: mp64_mmio_pkg.sv
`default_nettype none

package mp64_mmio_pkg;

    // ============================================================
    // MMIO address and data
    // ============================================================

    // Offset width inside the MMIO window
    localparam int MMIO_ADDR_W  = 12;

    // MMIO read and write data width
    localparam int MMIO_DATA_W  = 64;

    // Region code sits in the top bits of the offset
    localparam int REGION_W     = 4;

    // Peripherals return one byte
    localparam int PERIPH_DATA_W = 8;

    // ============================================================
    // Region codes
    // ============================================================
    localparam logic [REGION_W-1:0] REGION_UART     = 4'h0;
    localparam logic [REGION_W-1:0] REGION_TIMER    = 4'h1;
    localparam logic [REGION_W-1:0] REGION_DISK     = 4'h2;
    localparam logic [REGION_W-1:0] REGION_SYSINFO  = 4'h3;
    localparam logic [REGION_W-1:0] REGION_NIC      = 4'h4;
    localparam logic [REGION_W-1:0] REGION_MBOX     = 4'h5;
    // Spinlocks live behind the mailbox select
    localparam logic [REGION_W-1:0] REGION_SPINLOCK = 4'h6;

    // ============================================================
    // System-information registers
    // ============================================================
    localparam int SYSINFO_OFS_W = 8;

    localparam logic [SYSINFO_OFS_W-1:0] SYSINFO_OFS_ID    = 8'h00;
    localparam logic [SYSINFO_OFS_W-1:0] SYSINFO_OFS_RAM   = 8'h08;
    localparam logic [SYSINFO_OFS_W-1:0] SYSINFO_OFS_CORES = 8'h10;

    // "MP64" in ASCII, then major 2, minor 1
    localparam logic [63:0] SYSINFO_ID     = 64'h4D50_3634_0002_0001;

    // 1 MiB of on-chip RAM
    localparam logic [63:0] RAM_SIZE_BYTES = 64'd1048576;

endpackage

`default_nettype wire

// File: mp64_rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module mp64_rr_arbiter
    import mp64_bus_pkg::*;
#(
    parameter type payload_t = logic
) (
    input  wire logic                   sys_clk,
    input  wire logic                   sys_rst_n,

    // Requester side
    input  wire logic [NUM_CORES-1:0]   req_valid,
    input  wire payload_t               req_payload [NUM_CORES],
    output logic      [NUM_CORES-1:0]   req_ack,
    output logic      [TILE_DATA_W-1:0] req_rdata,

    // Responder side
    output logic                        out_req,
    output payload_t                    out_payload,
    input  wire logic [TILE_DATA_W-1:0] out_rdata,
    input  wire logic                   out_ack
);

    // ============================================================
    // Arbiter state
    // ============================================================
    logic [CORE_ID_BITS-1:0] grant;
    logic [CORE_ID_BITS-1:0] last_grant;
    logic                    busy;

    // Search result
    logic [CORE_ID_BITS-1:0] next_grant;
    logic                    any_req;

    // Rotating priority
    // Start one past the last winner, the last winner is checked last
    always_comb begin : rr_search
        logic [CORE_ID_BITS-1:0] cand;
        next_grant = last_grant;
        any_req    = 1'b0;
        cand       = last_grant;
        for (int off = 1; off <= NUM_CORES; off++) begin
            // Index wraps at the grant width
            cand = last_grant + CORE_ID_BITS'(off);
            if (!any_req && req_valid[cand]) begin
                next_grant = cand;
                any_req    = 1'b1;
            end
        end
    end

    // Idle -> busy on any request, busy -> idle on the responder's ack
    // Only one transfer in flight, so grants are always spaced by an idle cycle
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            grant      <= '0;
            last_grant <= '0;
            busy       <= 1'b0;
        end else if (busy) begin
            if (out_ack) begin
                busy       <= 1'b0;
                last_grant <= grant;
            end
        end else if (any_req) begin
            grant <= next_grant;
            busy  <= 1'b1;
        end
    end

    // ============================================================
    // Forward path
    // ============================================================

    // Request goes out only once the grant is latched
    assign out_req     = busy;
    assign out_payload = req_payload[grant];

    // ============================================================
    // Return path
    // ============================================================

    // Ack steered to the winner in the same cycle
    always_comb begin
        req_ack = '0;
        if (busy && out_ack) begin
            req_ack[grant] = 1'b1;
        end
    end

    // read data is broadcast, requesters qualify it with their ack
    assign req_rdata = out_rdata;

    // ============================================================
    // Checks
    // ============================================================

    // Every responder ack lands on exactly one requester
    a_ack_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        out_ack |-> $onehot(req_ack))
        else $error("arbiter: responder ack not routed to exactly one requester");

    // Winner keeps requesting until it has been acked
    a_grant_held: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        busy |-> req_valid[grant])
        else $error("arbiter: granted requester dropped its request");

    // Back-pressure holds the forwarded payload
    a_payload_stable: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
        (out_req && !out_ack) |=> $stable(out_payload))
        else $error("arbiter: payload changed while waiting for ack");

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 10
) (
    output logic sys_clk,
    output logic sys_rst_n
);

    // Free-running clock
    initial begin
        sys_clk = 1'b0;
        forever #(PERIOD_NS / 2) sys_clk = ~sys_clk;
    end

    // Reset held low, released on a rising edge
    initial begin
        sys_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clk);
        sys_rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

// File: tb_mp64_tasks.svh
`ifndef TB_MP64_TASKS_SVH
`define TB_MP64_TASKS_SVH

// ============================================================
// Checking and reporting
// ============================================================
task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
        error_count++;
        $display("error at %0t ns: %s expected %h got %h", $time, name, exp, act);
    end
endtask

task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count != errs_before) begin
        tests_failed++;
    end
    $display("test %s: %s", name, (error_count == errs_before) ? "ok" : "mismatch");
endtask

// Per-core payload patterns, round keeps rounds apart
function automatic logic [19:0] tile_addr_of(input int core, input int round);
    return 20'(32'h1000 * (core + 1) + round * 16 + core);
endfunction

function automatic logic [63:0] tile_data_of(input int core, input int round);
    return {32'hC0DE_0000 | 32'(core), 32'(round)};
endfunction

function automatic logic [63:0] ext_addr_of(input int core, input int round);
    return 64'hFEED_0000_0000_0000 | (64'(core) << 40) | (64'(round) << 8);
endfunction

// Round robin rule, first pending index after the last winner
function automatic int next_rr(input logic [3:0] pending, input logic [1:0] last);
    logic [1:0] idx;
    for (int off = 1; off <= 4; off++) begin
        idx = last + 2'(off);
        if (pending[idx]) begin
            return idx;
        end
    end
    return -1;
endfunction

// ============================================================
// Path drivers
// ============================================================

// Raise the masked on-chip requests, check each grant as it is acked
task automatic tile_round(input logic [3:0] mask, input int round);
    logic [3:0] pending;
    int         exp_core;
    int         cycles;
    @(posedge sys_clk);
    for (int i = 0; i < 4; i++) begin
        if (mask[i]) begin
            tile_req[i]                <= 1'b1;
            tile_addr[i*20 +: 20]      <= tile_addr_of(i, round);
            tile_wen[i]                <= i[0];
            tile_wdata[i*64 +: 64]     <= tile_data_of(i, round);
        end
    end
    pending = mask;
    cycles  = 0;
    while (pending != 0 && cycles < 100) begin
        @(negedge sys_clk);
        cycles++;
        if (tile_ack != 0) begin
            exp_core = next_rr(pending, tile_last);
            check("tile_ack", 64'(4'b1 << exp_core), 64'(tile_ack));
            check("mem_addr", 64'(tile_addr_of(exp_core, round)), 64'(mem_addr));
            check("mem_wen", 64'(exp_core % 2), 64'(mem_wen));
            check("mem_wdata", tile_data_of(exp_core, round), mem_wdata);
            check("tile_rdata", 64'(tile_addr_of(exp_core, round)) + MEM_OFS, tile_rdata);
            pending[exp_core] = 1'b0;
            tile_last         = 2'(exp_core);
            @(posedge sys_clk);
            tile_req[exp_core] <= 1'b0;
        end
    end
    if (pending != 0) begin
        error_count++;
        $display("on-chip ack never came for requesters %b", pending);
    end
endtask

// External path, same rules with wide addresses
task automatic ext_round(input logic [3:0] mask, input int round);
    logic [3:0] pending;
    int         exp_core;
    int         cycles;
    @(posedge sys_clk);
    for (int i = 0; i < 4; i++) begin
        if (mask[i]) begin
            ext_req[i]             <= 1'b1;
            ext_addr[i*64 +: 64]   <= ext_addr_of(i, round);
            ext_wen[i]             <= ~i[0];
            ext_wdata[i*64 +: 64]  <= ~tile_data_of(i, round);
        end
    end
    pending = mask;
    cycles  = 0;
    while (pending != 0 && cycles < 100) begin
        @(negedge sys_clk);
        cycles++;
        if (ext_ack != 0) begin
            exp_core = next_rr(pending, ext_last);
            check("ext_ack", 64'(4'b1 << exp_core), 64'(ext_ack));
            check("xmem_addr", ext_addr_of(exp_core, round), xmem_addr);
            check("xmem_wen", 64'(1 - exp_core % 2), 64'(xmem_wen));
            check("xmem_wdata", ~tile_data_of(exp_core, round), xmem_wdata);
            check("ext_rdata", ext_addr_of(exp_core, round) + XMEM_OFS, ext_rdata);
            pending[exp_core] = 1'b0;
            ext_last          = 2'(exp_core);
            @(posedge sys_clk);
            ext_req[exp_core] <= 1'b0;
        end
    end
    if (pending != 0) begin
        error_count++;
        $display("external ack never came for requesters %b", pending);
    end
endtask

// One MMIO access, checked in its own cycle
task automatic mmio_read(input logic [11:0] addr, input logic [4:0] exp_sel,
                         input logic [63:0] exp_data);
    logic [63:0] wdata;
    wdata = {4{4'hA, addr}};
    @(posedge sys_clk);
    mmio_req   <= 1'b1;
    mmio_addr  <= addr;
    // Write strobe follows address parity so both levels reach the peripherals
    mmio_wen   <= ^addr;
    mmio_wdata <= wdata;
    @(negedge sys_clk);
    check("sel {uart,timer,disk,nic,mbox}", 64'(exp_sel),
          64'({uart_sel, timer_sel, disk_sel, nic_sel, mbox_sel}));
    check("mmio_rdata", exp_data, mmio_rdata);
    check("mmio_ack", 64'(1), 64'(mmio_ack));
    check("periph_wen", 64'(^addr), 64'(periph_wen));
    check("periph_wdata", wdata, periph_wdata);
    @(posedge sys_clk);
    mmio_req <= 1'b0;
    mmio_wen <= 1'b0;
endtask

// ============================================================
// Directed tests
// ============================================================
task automatic test_reset_state();
    int errs;
    errs = error_count;
    @(posedge sys_rst_n);
    @(negedge sys_clk);
    check("mem_req", 0, 64'(mem_req));
    check("xmem_req", 0, 64'(xmem_req));
    check("tile_ack", 0, 64'(tile_ack));
    check("ext_ack", 0, 64'(ext_ack));
    check("mmio_ack", 0, 64'(mmio_ack));
    check("sel {uart,timer,disk,nic,mbox}", 0,
          64'({uart_sel, timer_sel, disk_sel, nic_sel, mbox_sel}));
    finish_test("reset_state", errs);
endtask

// Core 0 alone, forwarded request lags one cycle
task automatic test_single_tile();
    int errs;
    int cycles;
    errs = error_count;
    @(posedge sys_clk);
    tile_req[0]        <= 1'b1;
    tile_addr[19:0]    <= tile_addr_of(0, 0);
    tile_wen[0]        <= 1'b1;
    tile_wdata[63:0]   <= tile_data_of(0, 0);
    @(negedge sys_clk);
    check("mem_req", 0, 64'(mem_req));
    @(negedge sys_clk);
    check("mem_req", 1, 64'(mem_req));
    check("mem_addr", 64'(tile_addr_of(0, 0)), 64'(mem_addr));
    check("mem_wen", 1, 64'(mem_wen));
    check("mem_wdata", tile_data_of(0, 0), mem_wdata);
    cycles = 0;
    while (tile_ack == 0 && cycles < 20) begin
        @(negedge sys_clk);
        cycles++;
    end
    if (tile_ack == 0) begin
        error_count++;
        $display("single requester ack never came");
    end else begin
        check("tile_ack", 64'b0001, 64'(tile_ack));
        check("tile_rdata", 64'(tile_addr_of(0, 0)) + MEM_OFS, tile_rdata);
        tile_last = 2'd0;
    end
    @(posedge sys_clk);
    tile_req[0] <= 1'b0;
    finish_test("single_tile", errs);
endtask

// First round runs 1 2 3 0, second round skips core 1
task automatic test_four_way_tile();
    int errs;
    errs = error_count;
    tile_round(4'b1111, 1);
    tile_round(4'b1101, 2);
    finish_test("four_way_tile", errs);
endtask

task automatic test_concurrent_ext();
    int errs;
    errs = error_count;
    fork
        tile_round(4'b1111, 3);
        ext_round(4'b1111, 0);
    join
    finish_test("concurrent_ext", errs);
endtask

// Region 6 shares the mailbox select, region F is unmapped
task automatic test_mmio_regions();
    int errs;
    errs = error_count;
    mmio_read(12'h010, 5'b10000, 64'(UART_BYTE));
    mmio_read(12'h120, 5'b01000, 64'(TIMER_BYTE));
    mmio_read(12'h230, 5'b00100, 64'(DISK_BYTE));
    mmio_read(12'h300, 5'b00000, 64'h4D50_3634_0002_0001);
    mmio_read(12'h440, 5'b00010, 64'(NIC_BYTE));
    mmio_read(12'h550, 5'b00001, 64'(MBOX_BYTE));
    mmio_read(12'h660, 5'b00001, 64'(MBOX_BYTE));
    mmio_read(12'hF00, 5'b00000, 64'h0);
    finish_test("mmio_regions", errs);
endtask

task automatic test_sysinfo();
    int errs;
    errs = error_count;
    mmio_read(12'h300, 5'b00000, 64'h4D50_3634_0002_0001);
    mmio_read(12'h308, 5'b00000, 64'd1048576);
    mmio_read(12'h310, 5'b00000, 64'd4);
    mmio_read(12'h318, 5'b00000, 64'd0);
    finish_test("sysinfo", errs);
endtask

`endif

// File: tb_mp64_fabric.sv
`timescale 1ns/1ns
`default_nettype none

module tb_mp64_fabric;

    // ============================================================
    // Constants
    // ============================================================
    localparam int NUM_TESTS = 6;
    localparam int CLK_NS    = 40;

    // Memory models answer with address plus these offsets
    localparam logic [63:0] MEM_OFS  = 64'h0000_5A5A_0000_1000;
    localparam logic [63:0] XMEM_OFS = 64'h0000_0000_3C3C_0007;

    // Peripheral read bytes, all distinct
    localparam logic [7:0] UART_BYTE  = 8'hA1;
    localparam logic [7:0] TIMER_BYTE = 8'hB2;
    localparam logic [7:0] DISK_BYTE  = 8'hC3;
    localparam logic [7:0] NIC_BYTE   = 8'hD4;
    localparam logic [7:0] MBOX_BYTE  = 8'hE5;

    // ============================================================
    // DUT signals
    // ============================================================
    logic         sys_clk;
    logic         sys_rst_n;
    logic [3:0]   tile_req;
    logic [79:0]  tile_addr;
    logic [3:0]   tile_wen;
    logic [255:0] tile_wdata;
    logic [3:0]   tile_ack;
    logic [63:0]  tile_rdata;
    logic         mem_req;
    logic [19:0]  mem_addr;
    logic         mem_wen;
    logic [63:0]  mem_wdata;
    logic [63:0]  mem_rdata;
    logic         mem_ack;
    logic [3:0]   ext_req;
    logic [255:0] ext_addr;
    logic [3:0]   ext_wen;
    logic [255:0] ext_wdata;
    logic [3:0]   ext_ack;
    logic [63:0]  ext_rdata;
    logic         xmem_req;
    logic [63:0]  xmem_addr;
    logic         xmem_wen;
    logic [63:0]  xmem_wdata;
    logic [63:0]  xmem_rdata;
    logic         xmem_ack;
    logic         mmio_req;
    logic [11:0]  mmio_addr;
    logic         mmio_wen;
    logic [63:0]  mmio_wdata;
    logic [63:0]  mmio_rdata;
    logic         mmio_ack;
    logic         uart_sel;
    logic         timer_sel;
    logic         disk_sel;
    logic         nic_sel;
    logic         mbox_sel;
    logic         periph_wen;
    logic [63:0]  periph_wdata;

    // Bookkeeping
    int          error_count;
    int          tests_run;
    int          tests_failed;
    logic [7:0]  lfsr_state;
    logic [1:0]  tile_last;
    logic [1:0]  ext_last;

    tb_clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(10)) u_clk (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n)
    );

    mp64_fabric u_dut (
        .sys_clk(sys_clk), .sys_rst_n(sys_rst_n),
        .tile_req(tile_req), .tile_addr(tile_addr), .tile_wen(tile_wen),
        .tile_wdata(tile_wdata), .tile_ack(tile_ack), .tile_rdata(tile_rdata),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_wen(mem_wen),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata), .mem_ack(mem_ack),
        .ext_req(ext_req), .ext_addr(ext_addr), .ext_wen(ext_wen),
        .ext_wdata(ext_wdata), .ext_ack(ext_ack), .ext_rdata(ext_rdata),
        .xmem_req(xmem_req), .xmem_addr(xmem_addr), .xmem_wen(xmem_wen),
        .xmem_wdata(xmem_wdata), .xmem_rdata(xmem_rdata), .xmem_ack(xmem_ack),
        .mmio_req(mmio_req), .mmio_addr(mmio_addr), .mmio_wen(mmio_wen),
        .mmio_wdata(mmio_wdata), .mmio_rdata(mmio_rdata), .mmio_ack(mmio_ack),
        .uart_sel(uart_sel), .timer_sel(timer_sel), .disk_sel(disk_sel),
        .nic_sel(nic_sel), .mbox_sel(mbox_sel),
        .periph_wen(periph_wen), .periph_wdata(periph_wdata),
        .uart_rdata(UART_BYTE), .timer_rdata(TIMER_BYTE), .disk_rdata(DISK_BYTE),
        .nic_rdata(NIC_BYTE), .mbox_rdata(MBOX_BYTE)
    );

    // ============================================================
    // Random source
    // ============================================================

    // 8-bit Fibonacci LFSR, taps 8 6 5 4, one step per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3];
        lfsr_state = {lfsr_state[6:0], fb};
        return fb;
    endfunction

    // ============================================================
    // Memory models
    // ============================================================
    int  mem_wait;
    bit  mem_busy;
    int  xmem_wait;
    bit  xmem_busy;

    // Ack 0 to 3 cycles after the request is first seen
    always @(posedge sys_clk) begin
        if (mem_ack) begin
            mem_ack  <= 1'b0;
            mem_busy = 0;
        end else if (mem_req) begin
            if (!mem_busy) begin
                mem_busy = 1;
                mem_wait = {lfsr_bit(), lfsr_bit()};
            end
            if (mem_wait == 0) begin
                mem_ack   <= 1'b1;
                mem_rdata <= 64'(mem_addr) + MEM_OFS;
            end else begin
                mem_wait--;
            end
        end
    end

    // Same behavior on the external port
    always @(posedge sys_clk) begin
        if (xmem_ack) begin
            xmem_ack  <= 1'b0;
            xmem_busy = 0;
        end else if (xmem_req) begin
            if (!xmem_busy) begin
                xmem_busy = 1;
                xmem_wait = {lfsr_bit(), lfsr_bit()};
            end
            if (xmem_wait == 0) begin
                xmem_ack   <= 1'b1;
                xmem_rdata <= xmem_addr + XMEM_OFS;
            end else begin
                xmem_wait--;
            end
        end
    end

    `include "tb_mp64_tasks.svh"

    // ============================================================
    // Test sequence
    // ============================================================
    initial begin
        lfsr_state  = 8'd30;
        error_count = 0;
        tests_run   = 0;
        tests_failed = 0;
        tile_last   = 2'd0;
        ext_last    = 2'd0;
        mem_busy    = 0;
        xmem_busy   = 0;
        tile_req    <= '0;
        tile_addr   <= '0;
        tile_wen    <= '0;
        tile_wdata  <= '0;
        ext_req     <= '0;
        ext_addr    <= '0;
        ext_wen     <= '0;
        ext_wdata   <= '0;
        mem_rdata   <= '0;
        mem_ack     <= 1'b0;
        xmem_rdata  <= '0;
        xmem_ack    <= 1'b0;
        mmio_req    <= 1'b0;
        mmio_addr   <= '0;
        mmio_wen    <= 1'b0;
        mmio_wdata  <= '0;

        test_reset_state();
        test_single_tile();
        test_four_way_tile();
        test_concurrent_ext();
        test_mmio_regions();
        test_sysinfo();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
                 error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    // Bounded run time
    initial begin
        #(NUM_TESTS * 200 * CLK_NS);
        $display("watchdog expired before the tests completed");
        $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
